// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert -j 0
TOP        = fetch_unit_tb
RTL_TOP    = fetch_unit
FILELIST   = fetch_unit.f
BUILD_DIR  = obj_dir
LOG        = sim.log
RUN_ARGS   = +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) \
		hdl/cpu_arch_pkg.sv hdl/fetch_bus_pkg.sv hdl/next_pc_select.sv \
		hdl/fetch_addr_check.sv hdl/fetch_stage_out.sv hdl/fetch_unit.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/fetch_unit_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_checker
(
    input wire logic                          clk,
    input wire logic                          reset,
    input wire logic                          id_allow_in,
    input wire fetch_bus_pkg::br_bus_t        br_bus,
    input wire fetch_bus_pkg::redirect_t      redirect,
    input wire logic                          inst_sram_en,
    input wire logic [3:0]                    inst_sram_we,
    input wire logic [cpu_arch_pkg::xlen-1:0] inst_sram_addr,
    input wire logic                          if_valid
);

    int   assert_failures = 0;
    logic take_redirect;
    logic stalled;

    assign take_redirect = redirect.except_valid & (redirect.wb_ex | redirect.ertn_flush);
    assign stalled       = ~id_allow_in & ~take_redirect;

    // read-only port
    we_zero: assert property (@(posedge clk) inst_sram_we == 4'b0)
    else
    begin
        $error("instruction SRAM write strobe is not zero");
        assert_failures++;
    end

    en_low_in_reset: assert property (@(posedge clk) reset |-> !inst_sram_en)
    else
    begin
        $error("instruction SRAM enabled during reset");
        assert_failures++;
    end

    // held pc is presented again while decode stalls
    addr_stable_in_stall: assert property (@(posedge clk) disable iff (reset)
        (stalled && !$past(reset)) |-> $stable(inst_sram_addr))
    else
    begin
        $error("instruction SRAM address moved during a stall");
        assert_failures++;
    end

    no_valid_on_branch: assert property (@(posedge clk) br_bus.br_taken |-> !if_valid)
    else
    begin
        $error("bundle marked valid while a branch is taken");
        assert_failures++;
    end

endmodule

bind fetch_unit fetch_unit_checker fetch_unit_checker_i
(
    .clk            (clk),
    .reset          (reset),
    .id_allow_in    (id_allow_in),
    .br_bus         (br_bus),
    .redirect       (redirect),
    .inst_sram_en   (inst_sram_en),
    .inst_sram_we   (inst_sram_we),
    .inst_sram_addr (inst_sram_addr),
    .if_valid       (if_valid)
);

`default_nettype wire

// ==== dv/fetch_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb;

    localparam int          clk_period      = 8;
    localparam int          reset_cycles    = 4;
    localparam int          valid_wait_max  = 16;
    // worst case per test, counted from the cycles each task waits
    localparam int          seq_cycles      = 9 + valid_wait_max;
    localparam int          branch_cycles   = 3;
    // up to nine stalled cycles
    localparam int          stall_cycles    = 12;
    localparam int          redirect_cycles = 8;
    localparam int          test_cycles     = reset_cycles + seq_cycles + 4 * branch_cycles
                                              + 2 * stall_cycles + redirect_cycles;
    localparam int          watchdog_factor = 2;
    localparam logic [15:0] lfsr_seed       = 16'd9231;
    localparam logic [15:0] lfsr_taps       = 16'hb400;
    localparam logic [31:0] first_pc        = 32'h1c00_0000;
    localparam logic [31:0] era_target      = 32'h1c00_2000;
    localparam logic [31:0] entry_target    = 32'h1c00_8000;

    logic                      clk;
    logic                      reset;
    logic                      id_allow_in;
    fetch_bus_pkg::br_bus_t    br_bus;
    fetch_bus_pkg::redirect_t  redirect;
    logic [31:0]               inst_sram_rdata = '0;
    logic                      inst_sram_en;
    logic [3:0]                inst_sram_we;
    logic [31:0]               inst_sram_addr;
    logic [31:0]               inst_sram_wdata;
    logic                      if_ready_go;
    logic                      if_valid;
    fetch_bus_pkg::if_bundle_t if_bundle;

    logic [15:0] lfsr_state;
    logic [31:0] exp_pc;
    int          value_errors;
    int          other_errors;
    int          assert_errors;

    fetch_unit dut_i
    (
        .clk             (clk),
        .reset           (reset),
        .id_allow_in     (id_allow_in),
        .br_bus          (br_bus),
        .redirect        (redirect),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_we    (inst_sram_we),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_wdata (inst_sram_wdata),
        .inst_sram_rdata (inst_sram_rdata),
        .if_ready_go     (if_ready_go),
        .if_valid        (if_valid),
        .if_bundle       (if_bundle)
    );

    always #(clk_period / 2) clk = ~clk;

    // word address rotated left by 7, then scrambled
    function automatic logic [31:0] sram_word(input logic [31:0] addr);
        logic [31:0] word;
        word = {2'b00, addr[31:2]};
        return {word[24:0], word[31:25]} ^ 32'h5a5a_5a5a;
    endfunction

    // synchronous SRAM, one cycle read latency
    always @(posedge clk)
    begin
        if (inst_sram_en)
        begin
            inst_sram_rdata <= sram_word(inst_sram_addr);
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0])
        begin
            return (state >> 1) ^ lfsr_taps;
        end
        return state >> 1;
    endfunction

    // one LFSR step per bit
    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    // a faulting fetch carries ADEF in bit 0 and a zero word
    task automatic check_bundle(input logic [31:0] pc);
        logic        adef;
        logic [31:0] exp_inst;
        adef     = |pc[1:0];
        exp_inst = adef ? 32'h0 : sram_word(pc);
        compare("if_valid", 32'd1, 32'(if_valid));
        compare("if_bundle.pc", pc, if_bundle.pc);
        compare("if_bundle.inst", exp_inst, if_bundle.inst);
        compare("if_bundle.ebus", 32'(adef), 32'(if_bundle.ebus));
    endtask

    task automatic wait_valid();
        int waited;
        waited = 0;
        while (!if_valid && waited < valid_wait_max)
        begin
            next_cycle();
            @(negedge clk);
            waited++;
        end
        if (!if_valid)
        begin
            $display("no valid bundle appeared within %0d cycles", valid_wait_max);
            other_errors++;
        end
    endtask

    task automatic test_sequential();
        @(negedge clk);
        compare("if_valid", 32'd0, 32'(if_valid));
        compare("if_ready_go", 32'd1, 32'(if_ready_go));
        compare("inst_sram_we", 32'd0, 32'(inst_sram_we));
        compare("inst_sram_wdata", 32'd0, inst_sram_wdata);
        wait_valid();
        exp_pc = first_pc;
        check_bundle(exp_pc);
        for (int n = 0; n < 8; n++)
        begin
            next_cycle();
            @(negedge clk);
            exp_pc = exp_pc + 32'd4;
            check_bundle(exp_pc);
        end
    endtask

    // low_bits nonzero gives a misaligned target
    task automatic test_branch(input logic [1:0] low_bits);
        logic [31:0] bits;
        logic [31:0] target;
        take_bits(22, bits);
        target = {8'h1c, bits[21:0], low_bits};
        next_cycle();
        br_bus.br_target = target;
        br_bus.br_taken  = 1'b1;
        @(negedge clk);
        compare("if_valid", 32'd0, 32'(if_valid));
        compare("inst_sram_addr", target, inst_sram_addr);
        next_cycle();
        br_bus = '0;
        @(negedge clk);
        exp_pc = target;
        check_bundle(exp_pc);
        next_cycle();
        @(negedge clk);
        exp_pc = exp_pc + 32'd4;
        check_bundle(exp_pc);
    endtask

    task automatic test_stall();
        logic [31:0] bits;
        int          stall_len;
        take_bits(3, bits);
        stall_len = 2 + int'(bits[2:0]);
        next_cycle();
        id_allow_in = 1'b0;
        exp_pc      = exp_pc + 32'd4;
        @(negedge clk);
        compare("inst_sram_en", 32'd0, 32'(inst_sram_en));
        check_bundle(exp_pc);
        for (int n = 0; n < stall_len; n++)
        begin
            next_cycle();
            @(negedge clk);
            check_bundle(exp_pc);
        end
        next_cycle();
        id_allow_in = 1'b1;
        @(negedge clk);
        check_bundle(exp_pc);
        next_cycle();
        @(negedge clk);
        exp_pc = exp_pc + 32'd4;
        check_bundle(exp_pc);
    endtask

    // drive one redirect cycle, then clear it
    task automatic apply_redirect(input logic valid, input logic ertn, input logic ex);
        next_cycle();
        redirect.except_valid = valid;
        redirect.ertn_flush   = ertn;
        redirect.wb_ex        = ex;
        redirect.era_pc       = era_target;
        redirect.ex_entry     = entry_target;
        @(negedge clk);
        check_bundle(exp_pc);
        next_cycle();
        redirect = '0;
        @(negedge clk);
    endtask

    task automatic test_redirect();
        next_cycle();
        id_allow_in = 1'b0;
        exp_pc      = exp_pc + 32'd4;
        @(negedge clk);
        check_bundle(exp_pc);
        // return wins over entry, even while stalled
        apply_redirect(1'b1, 1'b1, 1'b1);
        exp_pc = era_target;
        check_bundle(exp_pc);
        apply_redirect(1'b1, 1'b0, 1'b1);
        exp_pc = entry_target;
        check_bundle(exp_pc);
        // flags without except_valid are ignored
        next_cycle();
        id_allow_in = 1'b1;
        @(negedge clk);
        check_bundle(exp_pc);
        exp_pc = exp_pc + 32'd4;
        apply_redirect(1'b0, 1'b1, 1'b1);
        exp_pc = exp_pc + 32'd4;
        check_bundle(exp_pc);
    endtask

    initial
    begin
        #(test_cycles * clk_period * watchdog_factor);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        logic [31:0] low;
        clk          = 1'b0;
        reset        = 1'b1;
        // decode ready during reset, the fetch must still stay quiet
        id_allow_in  = 1'b1;
        br_bus       = '0;
        redirect     = '0;
        lfsr_state   = lfsr_seed;
        exp_pc       = '0;
        value_errors = 0;
        other_errors = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;

        test_sequential();
        repeat (3) test_branch(2'b00);
        repeat (2) test_stall();
        test_redirect();
        take_bits(2, low);
        test_branch((low[1:0] == 2'b00) ? 2'b10 : low[1:0]);

        assert_errors = dut_i.fetch_unit_checker_i.assert_failures;
        $display("value errors %0d, other errors %0d, assertion failures %0d",
                 value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetch_unit.f ====
hdl/cpu_arch_pkg.sv
hdl/fetch_bus_pkg.sv
hdl/next_pc_select.sv
hdl/fetch_addr_check.sv
hdl/fetch_stage_out.sv
hdl/fetch_unit.sv
dv/fetch_unit_checker.sv
dv/fetch_unit_tb.sv

// ==== hdl/cpu_arch_pkg.sv ====
`default_nettype none

// architectural constants for the fetch subsystem
package cpu_arch_pkg;

    // data and address width of the core
    localparam int unsigned xlen = 32;

    // bytes per instruction, also the sequential PC step
    localparam int unsigned inst_bytes = 4;

    // value held in the PC during reset
    // first fetch after reset lands on 1c000000
    localparam logic [xlen-1:0] reset_pc = 32'h1bff_fffc;

    // one-hot exception bus carried along the pipeline
    localparam int unsigned ebus_width = 16;

    // fetch address error flag position
    localparam int unsigned ecode_adef_bit = 0;

    // word handed to decode when the fetch faulted
    localparam logic [xlen-1:0] inst_nop_zero = '0;

endpackage

`default_nettype wire

// ==== hdl/fetch_addr_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_addr_check
(
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic [cpu_arch_pkg::xlen-1:0] pc_next,
    input  wire logic                          pc_update,
    output fetch_bus_pkg::ebus_t               ebus
);

    logic                 adef;
    fetch_bus_pkg::ebus_t ebus_next;

    // instructions are word aligned
    assign adef = |pc_next[1:0];

    always_comb
    begin
        ebus_next                              = '0;
        ebus_next[cpu_arch_pkg::ecode_adef_bit] = adef;
    end

    // same enable as the PC register, so flags stay with their pc
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ebus <= '0;
        end
        else if (pc_update)
        begin
            ebus <= ebus_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_bus_pkg.sv ====
`default_nettype none

// buses crossing the fetch stage boundary
package fetch_bus_pkg;

    // branch result from the later stage
    // packs as {br_target, br_taken}
    typedef struct packed {
        logic [cpu_arch_pkg::xlen-1:0] br_target;
        logic                          br_taken;
    } br_bus_t;

    // exception entry and return requests from writeback
    typedef struct packed {
        logic                          except_valid;
        logic                          wb_ex;
        logic [cpu_arch_pkg::xlen-1:0] ex_entry;
        logic                          ertn_flush;
        logic [cpu_arch_pkg::xlen-1:0] era_pc;
    } redirect_t;

    // one-hot exception flags
    typedef logic [cpu_arch_pkg::ebus_width-1:0] ebus_t;

    // IF to ID bundle, ordered {ebus, inst, pc}
    typedef struct packed {
        ebus_t                         ebus;
        logic [cpu_arch_pkg::xlen-1:0] inst;
        logic [cpu_arch_pkg::xlen-1:0] pc;
    } if_bundle_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_stage_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage_out
(
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic [cpu_arch_pkg::xlen-1:0] pc,
    input  wire fetch_bus_pkg::ebus_t          ebus,
    input  wire logic [cpu_arch_pkg::xlen-1:0] inst_sram_rdata,
    input  wire logic                          br_taken,
    output logic                               if_valid,
    output fetch_bus_pkg::if_bundle_t          if_bundle
);

    logic                          stage_valid;
    logic                          fetch_fault;
    logic [cpu_arch_pkg::xlen-1:0] inst;

    // low through reset and the first cycle after it,
    // since no read data is back yet
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stage_valid <= 1'b0;
        end
        else
        begin
            stage_valid <= 1'b1;
        end
    end

    assign fetch_fault = ebus[cpu_arch_pkg::ecode_adef_bit];

    // a faulting fetch must not hand real data to decode
    assign inst = fetch_fault ? cpu_arch_pkg::inst_nop_zero : inst_sram_rdata;

    always_comb
    begin
        if_bundle.ebus = ebus;
        if_bundle.inst = inst;
        if_bundle.pc   = pc;
    end

    // wrong-path word while the branch is being taken
    assign if_valid = stage_valid & ~br_taken;

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
(
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          id_allow_in,
    input  wire fetch_bus_pkg::br_bus_t        br_bus,
    input  wire fetch_bus_pkg::redirect_t      redirect,

    // instruction SRAM, read only
    output logic                               inst_sram_en,
    output logic      [3:0]                    inst_sram_we,
    output logic      [cpu_arch_pkg::xlen-1:0] inst_sram_addr,
    output logic      [cpu_arch_pkg::xlen-1:0] inst_sram_wdata,
    input  wire logic [cpu_arch_pkg::xlen-1:0] inst_sram_rdata,

    // towards decode
    output logic                               if_ready_go,
    output logic                               if_valid,
    output fetch_bus_pkg::if_bundle_t          if_bundle
);

    logic [cpu_arch_pkg::xlen-1:0] pc_next;
    logic                          pc_update;
    logic [cpu_arch_pkg::xlen-1:0] pc;
    fetch_bus_pkg::ebus_t          ebus;

    next_pc_select next_pc_select_i
    (
        .clk            (clk),
        .reset          (reset),
        .id_allow_in    (id_allow_in),
        .br_bus         (br_bus),
        .redirect       (redirect),
        .pc_next        (pc_next),
        .pc_update      (pc_update),
        .pc             (pc),
        .inst_sram_en   (inst_sram_en),
        .inst_sram_addr (inst_sram_addr)
    );

    fetch_addr_check fetch_addr_check_i
    (
        .clk       (clk),
        .reset     (reset),
        .pc_next   (pc_next),
        .pc_update (pc_update),
        .ebus      (ebus)
    );

    fetch_stage_out fetch_stage_out_i
    (
        .clk             (clk),
        .reset           (reset),
        .pc              (pc),
        .ebus            (ebus),
        .inst_sram_rdata (inst_sram_rdata),
        .br_taken        (br_bus.br_taken),
        .if_valid        (if_valid),
        .if_bundle       (if_bundle)
    );

    // no write path
    assign inst_sram_we    = 4'b0;
    assign inst_sram_wdata = '0;

    // fetch always finishes in one cycle
    assign if_ready_go = 1'b1;

endmodule

`default_nettype wire

// ==== hdl/next_pc_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module next_pc_select
(
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire logic                          id_allow_in,
    input  wire fetch_bus_pkg::br_bus_t        br_bus,
    input  wire fetch_bus_pkg::redirect_t      redirect,
    output logic      [cpu_arch_pkg::xlen-1:0] pc_next,
    output logic                               pc_update,
    output logic      [cpu_arch_pkg::xlen-1:0] pc,
    output logic                               inst_sram_en,
    output logic      [cpu_arch_pkg::xlen-1:0] inst_sram_addr
);

    logic [cpu_arch_pkg::xlen-1:0] pc_seq;
    logic                          take_ertn;
    logic                          take_ex;
    logic                          take_redirect;

    // redirects only count with except_valid
    assign take_ertn     = redirect.except_valid & redirect.ertn_flush;
    assign take_ex       = redirect.except_valid & redirect.wb_ex;
    assign take_redirect = take_ertn | take_ex;

    assign pc_seq = pc + cpu_arch_pkg::xlen'(cpu_arch_pkg::inst_bytes);

    // priority: return, entry, branch, sequential
    always_comb
    begin
        if (take_ertn)
        begin
            pc_next = redirect.era_pc;
        end
        else if (take_ex)
        begin
            pc_next = redirect.ex_entry;
        end
        else if (br_bus.br_taken)
        begin
            pc_next = br_bus.br_target;
        end
        else
        begin
            pc_next = pc_seq;
        end
    end

    // a redirect overrides back-pressure from decode
    assign pc_update = id_allow_in | take_redirect;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= cpu_arch_pkg::reset_pc;
        end
        else if (pc_update)
        begin
            pc <= pc_next;
        end
    end

    // request the next word, or repeat the held one while stalled
    assign inst_sram_en   = (id_allow_in & ~reset) | take_redirect;
    assign inst_sram_addr = pc_update ? pc_next : pc;

endmodule

`default_nettype wire
